// ==== src/gcm_math_pkg.sv ====
package gcm_math_pkg;

    // ====================
    // Field widths.
    // ====================

    // One GHASH block.
    localparam int NB_BLOCK = 128;

    // Blocks per input word. Also the lane count.
    localparam int N_LANES = 2;

    // Input word as streamed by the caller.
    localparam int NB_WORD = N_LANES * NB_BLOCK;

    // One field of the length block.
    localparam int NB_LENGTH = 64;

    // Reduction constant in reflected bit order.
    localparam logic [NB_BLOCK-1:0] GF_R = {8'he1, {(NB_BLOCK - 8){1'b0}}};

    // ====================
    // Length block.
    // ====================

    // Raw block view, or AAD length over text length.
    typedef union packed
    {
        logic [NB_BLOCK-1:0] raw;
        struct packed
        {
            logic [NB_LENGTH-1:0] aad_bits;
            logic [NB_LENGTH-1:0] text_bits;
        } field;
    } gcm_length_block_u;

    // ====================
    // GF(2^128) multiply.
    // ====================

    // Bit-reflected GCM product.
    // Bit 127 holds the x^0 coefficient.
    function automatic logic [NB_BLOCK-1:0] gf128_mul
    (
        input logic [NB_BLOCK-1:0] a,
        input logic [NB_BLOCK-1:0] b
    );
        logic [NB_BLOCK-1:0] z;
        logic [NB_BLOCK-1:0] v;
        z = {NB_BLOCK{1'b0}};
        v = b;
        // Walk A from its x^0 term upward.
        for (int i = NB_BLOCK - 1; i >= 0; i--)
        begin
            // Add the running multiple of B.
            if (a[i])
            begin
                z = z ^ v;
            end
            // Times x, folding the carry back in.
            if (v[0])
            begin
                v = (v >> 1) ^ GF_R;
            end
            else
            begin
                v = v >> 1;
            end
        end
        return z;
    endfunction

endpackage

// ==== src/ghash_frame_pkg.sv ====
package ghash_frame_pkg;

    // ====================
    // Frame counters.
    // ====================

    // Remaining-block counter. Up to 1023 blocks per frame.
    localparam int NB_BLOCK_COUNT = 10;

    // Low bits dropped from a bit length to get blocks.
    localparam int LOG2_BLOCK_BITS = 7;

    // Blocks carried by one lane item (1 or 2).
    localparam int NB_WORD_BLOCKS = 2;

    // ====================
    // Feeder states.
    // ====================

    localparam int NB_STATE = 2;
    localparam logic [NB_STATE-1:0] ST_IDLE = 2'd0;
    localparam logic [NB_STATE-1:0] ST_DATA = 2'd1;
    localparam logic [NB_STATE-1:0] ST_LENGTH = 2'd2;

    // Edge accepting the last word to o_tag_ready.
    localparam int TAG_LATENCY = 4;

endpackage

// ==== src/h_power_gen.sv ====
`timescale 1ns/10ps

module h_power_gen
(
    input  logic                              i_clock,
    input  logic                              i_reset,
    input  logic [gcm_math_pkg::NB_BLOCK-1:0] i_hash_subkey,
    input  logic                              i_load_key,
    output logic [gcm_math_pkg::NB_BLOCK-1:0] o_h1,
    output logic [gcm_math_pkg::NB_BLOCK-1:0] o_h2,
    output logic                              o_powers_ready
);

    import gcm_math_pkg::*;

    // Square of H still owed after a load.
    logic h2_pending;
    // Both powers held and consistent.
    logic powers_valid;

    // ====================
    // Power registers.
    // ====================

    // H^1 straight from the key input.
    always_ff @(posedge i_clock)
    begin
        if (i_load_key)
        begin
            o_h1 <= i_hash_subkey;
        end
    end

    // H^2 one cycle later, from the held H^1.
    always_ff @(posedge i_clock)
    begin
        if (h2_pending)
        begin
            o_h2 <= gf128_mul(o_h1, o_h1);
        end
    end

    // ====================
    // Ready tracking.
    // ====================

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            h2_pending   <= 1'b0;
            powers_valid <= 1'b0;
        end
        else if (i_load_key)
        begin
            h2_pending   <= 1'b1;
            powers_valid <= 1'b0;
        end
        else if (h2_pending)
        begin
            h2_pending   <= 1'b0;
            powers_valid <= 1'b1;
        end
    end

    // Drops already in the load cycle.
    // Low for the load cycle and the squaring cycle.
    assign o_powers_ready = powers_valid & ~i_load_key;

endmodule

// ==== src/ghash_feeder.sv ====
`timescale 1ns/10ps

module ghash_feeder
(
    input  logic                                      i_clock,
    input  logic                                      i_reset,
    input  logic                                      i_sop,
    input  logic                                      i_valid_text,
    input  logic [gcm_math_pkg::NB_WORD-1:0]          i_data_word,
    input  logic [gcm_math_pkg::NB_LENGTH-1:0]        i_length_text,
    input  logic [gcm_math_pkg::NB_LENGTH-1:0]        i_length_aad,
    input  logic                                      i_powers_ready,
    input  logic                                      i_clear_fault,
    output logic [gcm_math_pkg::NB_BLOCK-1:0]         o_lane_block0,
    output logic [gcm_math_pkg::NB_BLOCK-1:0]         o_lane_block1,
    output logic                                      o_lane_valid,
    output logic                                      o_first_word,
    output logic                                      o_last_word,
    output logic [ghash_frame_pkg::NB_WORD_BLOCKS-1:0] o_word_blocks,
    output logic                                      o_fault
);

    import gcm_math_pkg::*;
    import ghash_frame_pkg::*;

    logic [NB_STATE-1:0]       state;
    logic [NB_BLOCK_COUNT-1:0] remaining;
    logic [NB_BLOCK_COUNT-1:0] frame_blocks;
    logic [NB_BLOCK_COUNT-1:0] word_remaining;
    logic [NB_BLOCK_COUNT-1:0] word_step;
    logic                      sop_seen;
    logic                      start_frame;
    logic                      sop_fault;
    logic                      accept_word;
    logic                      pair_word;
    logic                      last_data;
    logic                      in_length;
    gcm_length_block_u         length_block;

    // ====================
    // Word decode.
    // ====================

    // Frames carry at least one block.
    assign frame_blocks = i_length_text[LOG2_BLOCK_BITS +: NB_BLOCK_COUNT];

    assign sop_seen    = i_sop & i_valid_text;
    assign start_frame = sop_seen & (state == ST_IDLE) & i_powers_ready;
    // SOP while busy or while H powers settle.
    assign sop_fault   = sop_seen & ((state != ST_IDLE) | ~i_powers_ready);

    // Mid-frame SOP only loses its start meaning.
    assign accept_word = start_frame | ((state == ST_DATA) & i_valid_text);
    assign in_length   = (state == ST_LENGTH);

    // Blocks left, counting this word.
    assign word_remaining = (state == ST_IDLE) ? frame_blocks : remaining;
    assign pair_word      = (word_remaining > NB_BLOCK_COUNT'(1));
    assign last_data      = (word_remaining <= NB_BLOCK_COUNT'(2));
    assign word_step      = pair_word ? NB_BLOCK_COUNT'(2) : NB_BLOCK_COUNT'(1);

    // Length block fields.
    always_comb
    begin
        length_block.field.aad_bits  = i_length_aad;
        length_block.field.text_bits = i_length_text;
    end

    // ====================
    // Frame FSM.
    // ====================

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state     <= ST_IDLE;
            remaining <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE, ST_DATA:
                begin
                    if (accept_word)
                    begin
                        remaining <= word_remaining - word_step;
                        state     <= last_data ? ST_LENGTH : ST_DATA;
                    end
                end
                // Length block goes out, data ignored.
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ====================
    // Lane registers.
    // ====================

    // Markers travel with the blocks.
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_lane_valid <= 1'b0;
            o_first_word <= 1'b0;
            o_last_word  <= 1'b0;
        end
        else
        begin
            o_lane_valid <= accept_word | in_length;
            o_first_word <= start_frame;
            o_last_word  <= in_length;
        end
    end

    // Upper half first in message order.
    // A lone block sits in the last lane (H^1).
    always_ff @(posedge i_clock)
    begin
        if (in_length)
        begin
            o_lane_block0 <= '0;
            o_lane_block1 <= length_block.raw;
            o_word_blocks <= NB_WORD_BLOCKS'(1);
        end
        else if (accept_word && pair_word)
        begin
            o_lane_block0 <= i_data_word[NB_WORD-1 -: NB_BLOCK];
            o_lane_block1 <= i_data_word[NB_BLOCK-1:0];
            o_word_blocks <= NB_WORD_BLOCKS'(2);
        end
        else if (accept_word)
        begin
            o_lane_block0 <= '0;
            o_lane_block1 <= i_data_word[NB_WORD-1 -: NB_BLOCK];
            o_word_blocks <= NB_WORD_BLOCKS'(1);
        end
    end

    // Sticky fault. A new fault wins over a clear.
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_fault <= 1'b0;
        end
        else if (sop_fault)
        begin
            o_fault <= 1'b1;
        end
        else if (i_clear_fault)
        begin
            o_fault <= 1'b0;
        end
    end

endmodule

// ==== src/gf_mult_lane.sv ====
`timescale 1ns/10ps

module gf_mult_lane
(
    input  logic                              i_clock,
    input  logic                              i_reset,
    input  logic [gcm_math_pkg::NB_BLOCK-1:0] i_block,
    input  logic [gcm_math_pkg::NB_BLOCK-1:0] i_power,
    input  logic                              i_valid,
    output logic [gcm_math_pkg::NB_BLOCK-1:0] o_product,
    output logic                              o_valid
);

    import gcm_math_pkg::*;

    // Block times its fixed power of H.
    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            o_product <= gf128_mul(i_block, i_power);
        end
    end

    // Valid one cycle behind the block.
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid;
        end
    end

endmodule

// ==== src/ghash_accumulator.sv ====
`timescale 1ns/10ps

module ghash_accumulator
(
    input  logic                                      i_clock,
    input  logic                                      i_reset,
    input  logic [gcm_math_pkg::NB_BLOCK-1:0]         i_product0,
    input  logic [gcm_math_pkg::NB_BLOCK-1:0]         i_product1,
    input  logic                                      i_valid,
    input  logic                                      i_first_word,
    input  logic                                      i_last_word,
    input  logic [ghash_frame_pkg::NB_WORD_BLOCKS-1:0] i_word_blocks,
    input  logic [gcm_math_pkg::NB_BLOCK-1:0]         i_h1,
    input  logic [gcm_math_pkg::NB_BLOCK-1:0]         i_h2,
    input  logic [gcm_math_pkg::NB_BLOCK-1:0]         i_ek_j0,
    input  logic [gcm_math_pkg::NB_BLOCK-1:0]         i_expected_tag,
    input  logic                                      i_verify,
    output logic [gcm_math_pkg::NB_BLOCK-1:0]         o_tag,
    output logic                                      o_tag_ready,
    output logic                                      o_fail
);

    import gcm_math_pkg::*;
    import ghash_frame_pkg::*;

    // Markers delayed to line up with the lane products.
    logic                      first_d;
    logic                      last_d;
    logic [NB_WORD_BLOCKS-1:0] blocks_d;
    // GHASH state and its next value.
    logic [NB_BLOCK-1:0]       y;
    logic [NB_BLOCK-1:0]       y_power;
    logic [NB_BLOCK-1:0]       y_mult;
    logic [NB_BLOCK-1:0]       y_next;
    logic [NB_BLOCK-1:0]       tag_next;
    // Final update done, tag due next edge.
    logic                      tag_pending;

    // ====================
    // Marker delay.
    // ====================

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            first_d  <= 1'b0;
            last_d   <= 1'b0;
            blocks_d <= '0;
        end
        else
        begin
            first_d  <= i_first_word;
            last_d   <= i_last_word;
            blocks_d <= i_word_blocks;
        end
    end

    // ====================
    // GHASH update.
    // ====================

    // Y advances by one H per block in the item.
    assign y_power = (blocks_d == NB_WORD_BLOCKS'(2)) ? i_h2 : i_h1;
    assign y_mult  = gf128_mul(y, y_power);
    // First item of a frame starts from Y = 0.
    assign y_next  = (first_d ? {NB_BLOCK{1'b0}} : y_mult) ^ i_product0 ^ i_product1;

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            y <= y_next;
        end
    end

    // ====================
    // Tag stage.
    // ====================

    assign tag_next = y ^ i_ek_j0;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            tag_pending <= 1'b0;
            o_tag_ready <= 1'b0;
            o_fail      <= 1'b0;
            o_tag       <= '0;
        end
        else
        begin
            tag_pending <= i_valid & last_d;
            o_tag_ready <= tag_pending;
            if (tag_pending)
            begin
                o_tag  <= tag_next;
                // Compare only in verify mode.
                o_fail <= i_verify & (tag_next != i_expected_tag);
            end
            else if (i_valid && first_d)
            begin
                // New frame under way.
                o_fail <= 1'b0;
            end
        end
    end

endmodule

// ==== src/gcm_tag_engine.sv ====
`timescale 1ns/10ps

module gcm_tag_engine
(
    input  logic                               i_clock,
    input  logic                               i_reset,
    input  logic [gcm_math_pkg::NB_BLOCK-1:0]  i_hash_subkey,
    input  logic                               i_load_key,
    input  logic                               i_sop,
    input  logic                               i_valid_text,
    input  logic [gcm_math_pkg::NB_WORD-1:0]   i_data_word,
    input  logic [gcm_math_pkg::NB_LENGTH-1:0] i_length_text,
    input  logic [gcm_math_pkg::NB_LENGTH-1:0] i_length_aad,
    input  logic [gcm_math_pkg::NB_BLOCK-1:0]  i_ek_j0,
    input  logic [gcm_math_pkg::NB_BLOCK-1:0]  i_expected_tag,
    input  logic                               i_verify,
    input  logic                               i_clear_fault,
    output logic [gcm_math_pkg::NB_BLOCK-1:0]  o_tag,
    output logic                               o_tag_ready,
    output logic                               o_fail,
    output logic                               o_fault
);

    // Powers of H, indexed by exponent.
    logic [gcm_math_pkg::NB_BLOCK-1:0]  h_power [1:gcm_math_pkg::N_LANES];
    logic                               powers_ready;
    // Feeder to lanes.
    logic [gcm_math_pkg::NB_BLOCK-1:0]  lane_block [0:gcm_math_pkg::N_LANES-1];
    logic                               feed_valid;
    logic                               first_word;
    logic                               last_word;
    logic [ghash_frame_pkg::NB_WORD_BLOCKS-1:0] word_blocks;
    // Lanes to accumulator.
    logic [gcm_math_pkg::NB_BLOCK-1:0]  lane_product [0:gcm_math_pkg::N_LANES-1];
    logic [gcm_math_pkg::N_LANES-1:0]   lane_valid;

    // ====================
    // Key powers.
    // ====================

    h_power_gen u_h_power_gen
    (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_hash_subkey  (i_hash_subkey),
        .i_load_key     (i_load_key),
        .o_h1           (h_power[1]),
        .o_h2           (h_power[2]),
        .o_powers_ready (powers_ready)
    );

    // ====================
    // Frame feeder.
    // ====================

    ghash_feeder u_ghash_feeder
    (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_sop          (i_sop),
        .i_valid_text   (i_valid_text),
        .i_data_word    (i_data_word),
        .i_length_text  (i_length_text),
        .i_length_aad   (i_length_aad),
        .i_powers_ready (powers_ready),
        .i_clear_fault  (i_clear_fault),
        .o_lane_block0  (lane_block[0]),
        .o_lane_block1  (lane_block[1]),
        .o_lane_valid   (feed_valid),
        .o_first_word   (first_word),
        .o_last_word    (last_word),
        .o_word_blocks  (word_blocks),
        .o_fault        (o_fault)
    );

    // ====================
    // Multiplier lanes.
    // ====================

    // Earlier blocks take the higher power.
    for (genvar j = 0; j < gcm_math_pkg::N_LANES; j++)
    begin : g_lane
        gf_mult_lane u_gf_mult_lane
        (
            .i_clock   (i_clock),
            .i_reset   (i_reset),
            .i_block   (lane_block[j]),
            .i_power   (h_power[gcm_math_pkg::N_LANES - j]),
            .i_valid   (feed_valid),
            .o_product (lane_product[j]),
            .o_valid   (lane_valid[j])
        );
    end

    // ====================
    // Accumulator and tag.
    // ====================

    ghash_accumulator u_ghash_accumulator
    (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_product0     (lane_product[0]),
        .i_product1     (lane_product[1]),
        .i_valid        (&lane_valid),
        .i_first_word   (first_word),
        .i_last_word    (last_word),
        .i_word_blocks  (word_blocks),
        .i_h1           (h_power[1]),
        .i_h2           (h_power[2]),
        .i_ek_j0        (i_ek_j0),
        .i_expected_tag (i_expected_tag),
        .i_verify       (i_verify),
        .o_tag          (o_tag),
        .o_tag_ready    (o_tag_ready),
        .o_fail         (o_fail)
    );

endmodule

// ==== sim/tb_gcm_tag_engine.sv ====
`timescale 1ns/10ps

module tb_gcm_tag_engine;

    // ====================
    // Constants.
    // ====================

    localparam int N_TESTS = 8;
    localparam int MAX_BLOCKS = 16;
    localparam int RESET_CYCLES = 5;
    localparam int TAG_WAIT_LIMIT = 20;
    localparam int TAG_LATENCY = 4;
    localparam logic [31:0] SEED_BASE = 32'h06672174;

    // Fault cases.
    localparam int FAULT_NONE = 0;
    localparam int FAULT_MID_FRAME = 1;
    localparam int FAULT_KEY_LOAD = 2;

    // GCM test case 2, zero key.
    localparam logic [127:0] KAT_H = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
    localparam logic [127:0] KAT_BLOCK = 128'h0388dace60b6a392f328c2b971b2fe78;
    localparam logic [127:0] KAT_EK_J0 = 128'h58e2fccefa7e3061367f1d57a4e7455a;
    localparam logic [127:0] KAT_TAG = 128'hab6e47d42cec13bdf53a67b21257bddf;
    // Two more subkeys for the key change cases.
    localparam logic [127:0] ALT_H = 128'hb83b533708bf535d0aa6e52980d53b78;
    localparam logic [127:0] ALT2_H = 128'h4d3a9f17c2e86b05a1f0d7346e9b28c5;

    // ====================
    // DUT.
    // ====================

    logic         i_clock;
    logic         i_reset;
    logic [127:0] i_hash_subkey;
    logic         i_load_key;
    logic         i_sop;
    logic         i_valid_text;
    logic [255:0] i_data_word;
    logic [63:0]  i_length_text;
    logic [63:0]  i_length_aad;
    logic [127:0] i_ek_j0;
    logic [127:0] i_expected_tag;
    logic         i_verify;
    logic         i_clear_fault;
    logic [127:0] o_tag;
    logic         o_tag_ready;
    logic         o_fail;
    logic         o_fault;

    gcm_tag_engine u_gcm_tag_engine
    (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_hash_subkey  (i_hash_subkey),
        .i_load_key     (i_load_key),
        .i_sop          (i_sop),
        .i_valid_text   (i_valid_text),
        .i_data_word    (i_data_word),
        .i_length_text  (i_length_text),
        .i_length_aad   (i_length_aad),
        .i_ek_j0        (i_ek_j0),
        .i_expected_tag (i_expected_tag),
        .i_verify       (i_verify),
        .i_clear_fault  (i_clear_fault),
        .o_tag          (o_tag),
        .o_tag_ready    (o_tag_ready),
        .o_fail         (o_fail),
        .o_fault        (o_fault)
    );

    // ====================
    // Table and state.
    // ====================

    // One row per test.
    logic [127:0] tbl_h       [0:N_TESTS-1];
    logic [127:0] tbl_ek      [0:N_TESTS-1];
    int           tbl_blocks  [0:N_TESTS-1];
    logic [63:0]  tbl_aad     [0:N_TESTS-1];
    logic         tbl_verify  [0:N_TESTS-1];
    logic         tbl_corrupt [0:N_TESTS-1];
    int           tbl_seed    [0:N_TESTS-1];
    int           tbl_fault   [0:N_TESTS-1];
    logic [127:0] tbl_tag     [0:N_TESTS-1];

    // Message blocks of the running test.
    logic [127:0] blocks [0:MAX_BLOCKS-1];
    integer       seed;
    int           cycle_count = 0;
    int           cycle_limit;
    int           error_count;
    int           tests_ok;
    int           tests_bad;
    logic         key_loaded;
    logic [127:0] loaded_h;

    // Free running clock.
    initial
    begin
        i_clock = 1'b0;
        forever #5 i_clock = ~i_clock;
    end

    // Watchdog.
    always @(posedge i_clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout: run went past its limit of %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic set_row
    (
        input int           idx,
        input logic [127:0] h,
        input logic [127:0] ek,
        input int           nblk,
        input logic [63:0]  aad,
        input logic         verify,
        input logic         corrupt,
        input int           seed_idx,
        input int           fault,
        input logic [127:0] tag
    );
        tbl_h[idx]       = h;
        tbl_ek[idx]      = ek;
        tbl_blocks[idx]  = nblk;
        tbl_aad[idx]     = aad;
        tbl_verify[idx]  = verify;
        tbl_corrupt[idx] = corrupt;
        tbl_seed[idx]    = seed_idx;
        tbl_fault[idx]   = fault;
        tbl_tag[idx]     = tag;
    endtask

    // Seed index 0 picks the known answer block. A zero tag means model only.
    task automatic fill_table;
        set_row(0, KAT_H, KAT_EK_J0, 1, 64'd0, 1'b1, 1'b0, 0, FAULT_NONE, KAT_TAG);
        set_row(1, KAT_H, 128'h3247184b3c4f69a44dbcd22887bbb418, 6, 64'd256,
                1'b0, 1'b1, 1, FAULT_NONE, '0);
        set_row(2, KAT_H, 128'h0b9c6e3f5a71d2084e6f19c3a5d7b2e1, 5, 64'd128,
                1'b1, 1'b0, 2, FAULT_NONE, '0);
        set_row(3, KAT_H, 128'hf00dcafe12345678a5a5a5a55a5a5a5a, 3, 64'd0,
                1'b1, 1'b1, 3, FAULT_NONE, '0);
        set_row(4, KAT_H, 128'h8e1f2a3b4c5d6e7f8091a2b3c4d5e6f7, 8, 64'd384,
                1'b0, 1'b0, 4, FAULT_MID_FRAME, '0);
        set_row(5, ALT_H, 128'h7cd21a5e009f3b8816e4c27da3b5f061, 4, 64'd0,
                1'b1, 1'b0, 5, FAULT_KEY_LOAD, '0);
        set_row(6, ALT_H, 128'h2b7e151628aed2a6abf7158809cf4f3c, 7, 64'd256,
                1'b1, 1'b1, 6, FAULT_NONE, '0);
        set_row(7, ALT2_H, 128'hc0ffee00112233445566778899aabbcc, 16, 64'd512,
                1'b1, 1'b0, 7, FAULT_NONE, '0);
    endtask

    // ====================
    // GHASH model.
    // ====================

    // Multiply by x in the reflected field.
    function automatic logic [127:0] mul_by_x(input logic [127:0] v);
        if (v[0])
        begin
            return (v >> 1) ^ {8'he1, 120'h0};
        end
        else
        begin
            return v >> 1;
        end
    endfunction

    // Horner form, highest degree of A first.
    function automatic logic [127:0] field_mul(input logic [127:0] a, input logic [127:0] b);
        logic [127:0] z;
        int           i;
        z = '0;
        for (i = 0; i < 128; i++)
        begin
            z = mul_by_x(z);
            if (a[i])
            begin
                z = z ^ b;
            end
        end
        return z;
    endfunction

    // One block at a time, then the length block.
    function automatic logic [127:0] ghash_tag
    (
        input logic [127:0] h,
        input logic [127:0] ek,
        input int           n,
        input logic [63:0]  aad_bits,
        input logic [63:0]  text_bits
    );
        logic [127:0] y;
        int           i;
        y = '0;
        for (i = 0; i < n; i++)
        begin
            y = field_mul(y ^ blocks[i], h);
        end
        y = field_mul(y ^ {aad_bits, text_bits}, h);
        return y ^ ek;
    endfunction

    function automatic logic [127:0] random_block;
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // ====================
    // Stimulus tasks.
    // ====================

    // Optionally fires an SOP while the powers of H settle.
    task automatic load_hash_key(input logic [127:0] h, input logic sop_while_settling);
        @(negedge i_clock);
        i_hash_subkey = h;
        i_load_key = 1'b1;
        @(negedge i_clock);
        i_load_key = 1'b0;
        if (sop_while_settling)
        begin
            i_sop = 1'b1;
            i_valid_text = 1'b1;
            i_data_word = {random_block(), random_block()};
        end
        @(negedge i_clock);
        i_sop = 1'b0;
        i_valid_text = 1'b0;
        if (sop_while_settling && o_fault !== 1'b1)
        begin
            $display("mismatch at %0t: o_fault after key load SOP expected 1 got %b", $time,
                     o_fault);
            error_count++;
        end
        @(negedge i_clock);
        loaded_h = h;
        key_loaded = 1'b1;
    endtask

    task automatic run_test(input int t);
        int           nblk;
        int           nwords;
        int           errors_before;
        int           wait_cycles;
        int           accept_count;
        int           latency;
        int           i;
        int           w;
        logic [127:0] model_tag;
        logic [127:0] lower;
        logic         got_ready;
        logic         exp_fail;
        logic         exp_fault;
        errors_before = error_count;
        nblk = tbl_blocks[t];
        nwords = (nblk + 1) / 2;
        seed = SEED_BASE + tbl_seed[t];
        if (!key_loaded || loaded_h != tbl_h[t])
        begin
            load_hash_key(tbl_h[t], tbl_fault[t] == FAULT_KEY_LOAD);
        end

        // Message and expected results.
        for (i = 0; i < nblk; i++)
        begin
            if (tbl_seed[t] == 0)
            begin
                blocks[i] = KAT_BLOCK;
            end
            else
            begin
                blocks[i] = random_block();
            end
        end
        model_tag = ghash_tag(tbl_h[t], tbl_ek[t], nblk, tbl_aad[t], 64'(nblk * 128));
        if (tbl_tag[t] != '0 && model_tag !== tbl_tag[t])
        begin
            $display("mismatch at %0t: model tag expected %h got %h", $time, tbl_tag[t],
                     model_tag);
            error_count++;
        end
        exp_fail = tbl_verify[t] & tbl_corrupt[t];
        exp_fault = (tbl_fault[t] != FAULT_NONE);

        @(negedge i_clock);
        i_ek_j0 = tbl_ek[t];
        i_verify = tbl_verify[t];
        i_expected_tag = tbl_corrupt[t] ? (model_tag ^ 128'h1) : model_tag;
        i_length_text = 64'(nblk * 128);
        i_length_aad = tbl_aad[t];

        // Upper half first. A lone last block leaves junk below it.
        for (w = 0; w < nwords; w++)
        begin
            @(negedge i_clock);
            if (2 * w + 1 < nblk)
            begin
                lower = blocks[2 * w + 1];
            end
            else
            begin
                lower = random_block();
            end
            i_data_word = {blocks[2 * w], lower};
            i_valid_text = 1'b1;
            i_sop = (w == 0) || ((tbl_fault[t] == FAULT_MID_FRAME) && (w == 1));
        end
        accept_count = cycle_count + 1;

        // Wait for the tag. A stray valid in the length cycle must be ignored.
        got_ready = 1'b0;
        wait_cycles = 0;
        latency = 0;
        while (!got_ready && wait_cycles < TAG_WAIT_LIMIT)
        begin
            @(negedge i_clock);
            wait_cycles++;
            i_sop = 1'b0;
            i_valid_text = (wait_cycles == 1);
            i_data_word = {random_block(), random_block()};
            // First word of this frame has cleared the previous verdict.
            if (wait_cycles == 3 && o_fail !== 1'b0)
            begin
                $display("mismatch at %0t: o_fail before tag expected 0 got %b", $time,
                         o_fail);
                error_count++;
            end
            if (o_tag_ready)
            begin
                got_ready = 1'b1;
                latency = cycle_count - accept_count;
            end
        end

        if (!got_ready)
        begin
            $display("test %0d: o_tag_ready never rose within %0d cycles", t, TAG_WAIT_LIMIT);
            error_count++;
        end
        else
        begin
            if (latency != TAG_LATENCY)
            begin
                $display("mismatch at %0t: tag latency expected %0d got %0d", $time,
                         TAG_LATENCY, latency);
                error_count++;
            end
            if (o_tag !== model_tag)
            begin
                $display("mismatch at %0t: o_tag expected %h got %h", $time, model_tag, o_tag);
                error_count++;
            end
            if (o_fail !== exp_fail)
            begin
                $display("mismatch at %0t: o_fail expected %b got %b", $time, exp_fail, o_fail);
                error_count++;
            end
        end

        @(negedge i_clock);
        if (o_tag_ready !== 1'b0)
        begin
            $display("mismatch at %0t: o_tag_ready after pulse expected 0 got %b", $time,
                     o_tag_ready);
            error_count++;
        end
        if (o_fault !== exp_fault)
        begin
            $display("mismatch at %0t: o_fault expected %b got %b", $time, exp_fault, o_fault);
            error_count++;
        end
        // Clear a latched fault.
        if (exp_fault)
        begin
            i_clear_fault = 1'b1;
            @(negedge i_clock);
            i_clear_fault = 1'b0;
            if (o_fault !== 1'b0)
            begin
                $display("mismatch at %0t: o_fault after clear expected 0 got %b", $time,
                         o_fault);
                error_count++;
            end
        end

        if (error_count == errors_before)
        begin
            tests_ok++;
        end
        else
        begin
            tests_bad++;
        end
        $display("test %0d: %0d blocks, verify %0b, fault case %0d, %0d errors", t, nblk,
                 tbl_verify[t], tbl_fault[t], error_count - errors_before);
    endtask

    // ====================
    // Main sequence.
    // ====================

    initial
    begin
        i_reset = 1'b1;
        i_hash_subkey = '0;
        i_load_key = 1'b0;
        i_sop = 1'b0;
        i_valid_text = 1'b0;
        i_data_word = '0;
        i_length_text = '0;
        i_length_aad = '0;
        i_ek_j0 = '0;
        i_expected_tag = '0;
        i_verify = 1'b0;
        i_clear_fault = 1'b0;
        error_count = 0;
        tests_ok = 0;
        tests_bad = 0;
        key_loaded = 1'b0;
        loaded_h = '0;
        seed = SEED_BASE;
        fill_table();

        // Blocks plus 20 cycles per test, and the reset.
        cycle_limit = RESET_CYCLES + 5;
        for (int t = 0; t < N_TESTS; t++)
        begin
            cycle_limit = cycle_limit + tbl_blocks[t] + 20;
        end

        repeat (RESET_CYCLES) @(negedge i_clock);
        i_reset = 1'b0;
        if (o_tag_ready !== 1'b0)
        begin
            $display("mismatch at %0t: o_tag_ready expected 0 got %b", $time, o_tag_ready);
            error_count++;
        end
        if (o_fail !== 1'b0)
        begin
            $display("mismatch at %0t: o_fail expected 0 got %b", $time, o_fail);
            error_count++;
        end
        if (o_fault !== 1'b0)
        begin
            $display("mismatch at %0t: o_fault expected 0 got %b", $time, o_fault);
            error_count++;
        end
        if (o_tag !== '0)
        begin
            $display("mismatch at %0t: o_tag expected %h got %h", $time, 128'h0, o_tag);
            error_count++;
        end

        for (int t = 0; t < N_TESTS; t++)
        begin
            run_test(t);
        end

        $display("tests %0d, clean %0d, with errors %0d, total errors %0d", N_TESTS,
                 tests_ok, tests_bad, error_count);
        if (error_count == 0)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
src/gcm_math_pkg.sv
src/ghash_frame_pkg.sv
src/h_power_gen.sv
src/ghash_feeder.sv
src/gf_mult_lane.sv
src/ghash_accumulator.sv
src/gcm_tag_engine.sv
sim/tb_gcm_tag_engine.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the GCM tag engine testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_gcm_tag_engine \
    --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1
